//--- design/stack_cpu_pkg.sv
package stack_cpu_pkg;

  // widths
  parameter int insn_w = 16;
  parameter int pc_w   = 10;  // 1k instruction words
  parameter int data_w = 8;
  parameter int addr_w = 8;   // 256-byte data RAM

  // a store here also goes out on the UART
  parameter logic [addr_w-1:0] tx_port_addr = 8'd1;

  // terminator of a downloaded program
  parameter logic [insn_w-1:0] prog_end_word = 16'hffff;

  parameter int led_stack_rows = 6;  // stack entries on the matrix

  // opcode in insn[15:8], operand in insn[7:0]
  typedef enum logic [7:0] {
    op_nop  = 8'h00,
    op_push = 8'h01,  // push operand
    op_pop  = 8'h02,
    op_dup  = 8'h03,
    op_add  = 8'h04,  // a + b
    op_sub  = 8'h05,  // a - b
    op_and  = 8'h06,
    op_or   = 8'h07,
    op_ld   = 8'h08,  // push mem[operand]
    op_st   = 8'h09,  // pop into mem[operand]
    op_jmp  = 8'h0a,
    op_jz   = 8'h0b,  // pop, jump if zero
    op_halt = 8'h0c
  } op_e;

  // cpu sequencer
  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mem_wait,
    st_halted
  } cpu_state_e;

endpackage

//--- design/uart.sv
module uart #(
  parameter int clks_per_bit = 234
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic       uart_tx,
  output logic [7:0] rx_data,
  output logic       rx_data_wr,
  input  logic [7:0] tx_data,
  input  logic       tx_en
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);
  // half a bit, less the synchroniser delay
  localparam logic [cnt_w-1:0] half_bit = cnt_w'(clks_per_bit / 2 - 3);

  logic [1:0]       rx_sync;
  logic             rx_busy;
  logic [cnt_w-1:0] rx_cnt;
  logic [3:0]       rx_bit;   // 0 start, 1..8 data, 9 stop
  logic [7:0]       rx_shift;

  logic             tx_busy;
  logic [cnt_w-1:0] tx_cnt;
  logic [3:0]       tx_bit;
  logic [8:0]       tx_shift; // data then stop bit, lsb first

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // idle line
    end else begin
      rx_sync <= {rx_sync[0], uart_rx};
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy    <= 1'b0;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_data_wr <= 1'b0;
    end else begin
      rx_data_wr <= 1'b0;
      if (!rx_busy) begin
        if (!rx_sync[1]) begin  // falling edge of start bit
          rx_busy <= 1'b1;
          rx_cnt  <= half_bit;
          rx_bit  <= '0;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        // mid-bit sample point
        rx_cnt <= full_bit;
        rx_bit <= rx_bit + 1'b1;
        if (rx_bit == 4'd0 && rx_sync[1]) begin
          rx_busy <= 1'b0;  // glitch, no real start bit
        end else if (rx_bit == 4'd9) begin
          rx_busy    <= 1'b0;
          rx_data_wr <= rx_sync[1];  // framing error drops the byte
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_busy && rx_cnt == '0) begin
      if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
        rx_shift <= {rx_sync[1], rx_shift[7:1]};
      end
      if (rx_bit == 4'd9) begin
        rx_data <= rx_shift;
      end
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      uart_tx <= 1'b1;
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
      tx_bit  <= '0;
    end else if (!tx_busy) begin
      if (tx_en) begin
        uart_tx <= 1'b0;  // start bit
        tx_busy <= 1'b1;
        tx_cnt  <= full_bit;
        tx_bit  <= '0;
      end
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - 1'b1;
    end else begin
      tx_cnt <= full_bit;
      tx_bit <= tx_bit + 1'b1;
      if (tx_bit == 4'd9) begin
        tx_busy <= 1'b0;  // end of stop bit, line stays high
      end else begin
        uart_tx <= tx_shift[0];
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!tx_busy && tx_en) begin
      tx_shift <= {1'b1, tx_data};
    end else if (tx_busy && tx_cnt == '0) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

endmodule

//--- design/program_loader.sv
module program_loader (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic [7:0]                       rx_data,
  input  logic                             rx_data_wr,
  output logic                             prog_we,
  output logic [stack_cpu_pkg::pc_w-1:0]   prog_addr,
  output logic [stack_cpu_pkg::insn_w-1:0] prog_wdata,
  output logic                             prog_done
);
  import stack_cpu_pkg::*;

  logic              phase;    // 1 while waiting for the low byte
  logic [insn_w-1:0] word;     // last two bytes received
  logic              end_word;

  assign end_word   = (word == prog_end_word);
  assign prog_wdata = word;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      word      <= '0;
      prog_we   <= 1'b0;
      prog_addr <= '0;
      prog_done <= 1'b0;
    end else begin
      if (rx_data_wr) begin
        phase <= ~phase;
        word  <= {word[7:0], rx_data};
      end
      prog_we <= rx_data_wr & phase;  // word complete after low byte

      if (prog_we && !end_word) begin
        prog_addr <= prog_addr + 1'b1;
      end else if (rx_data_wr && end_word) begin
        prog_addr <= '0;  // new program starts over
      end

      if (rx_data_wr) begin
        prog_done <= 1'b0;  // holds the cpu while loading
      end else if (prog_we && end_word) begin
        prog_done <= 1'b1;
      end
    end
  end

endmodule

//--- design/sdp_ram.sv
module sdp_ram #(
  parameter int addr_bits = 10,
  parameter int data_bits = 16
) (
  input  logic                 sys_clk,
  input  logic                 we,
  input  logic [addr_bits-1:0] waddr,
  input  logic [data_bits-1:0] wdata,
  input  logic [addr_bits-1:0] raddr,
  output logic [data_bits-1:0] rdata
);

  localparam int depth = 1 << addr_bits;

  logic [data_bits-1:0] mem [depth];

  // write port
  always_ff @(posedge sys_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge sys_clk) begin
    rdata <= mem[raddr];
  end

endmodule

//--- design/stack_cpu.sv
module stack_cpu #(
  parameter int stack_depth = 16
) (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic                             run,
  input  logic [stack_cpu_pkg::insn_w-1:0] insn,
  output logic [stack_cpu_pkg::pc_w-1:0]   pc,
  output logic [stack_cpu_pkg::addr_w-1:0] mem_addr,
  output logic                             mem_wr,
  output logic [stack_cpu_pkg::data_w-1:0] wr_data,
  input  logic [stack_cpu_pkg::data_w-1:0] rd_data,
  output logic [stack_cpu_pkg::led_stack_rows-1:0][stack_cpu_pkg::data_w-1:0] stack_view
);
  import stack_cpu_pkg::*;

  cpu_state_e        state;
  op_e               op;
  logic [data_w-1:0] operand;
  logic [data_w-1:0] stack [stack_depth];  // entry 0 is top
  logic              push_en;
  logic              pop_en;
  logic              alu_en;    // pop two, push result
  logic              take_jump;
  logic [data_w-1:0] push_val;
  logic [data_w-1:0] alu_res;

  assign op       = op_e'(insn[insn_w-1:data_w]);
  assign operand  = insn[data_w-1:0];
  assign mem_addr = insn[addr_w-1:0];
  assign mem_wr   = (state == st_exec) && (op == op_st);
  assign wr_data  = stack[0];

  always_comb begin
    push_en   = 1'b0;
    pop_en    = 1'b0;
    alu_en    = 1'b0;
    take_jump = 1'b0;
    push_val  = operand;
    case (op)
      op_add:  alu_res = stack[1] + stack[0];
      op_sub:  alu_res = stack[1] - stack[0];
      op_and:  alu_res = stack[1] & stack[0];
      op_or:   alu_res = stack[1] | stack[0];
      default: alu_res = '0;
    endcase
    if (state == st_mem_wait) begin
      push_en  = 1'b1;   // load data arrives now
      push_val = rd_data;
    end else if (state == st_exec) begin
      case (op)
        op_push: push_en = 1'b1;
        op_dup: begin
          push_en  = 1'b1;
          push_val = stack[0];
        end
        op_pop, op_st: pop_en = 1'b1;
        op_add, op_sub, op_and, op_or: alu_en = 1'b1;
        op_jmp: take_jump = 1'b1;
        op_jz: begin
          pop_en    = 1'b1;
          take_jump = (stack[0] == '0);
        end
        default: ;  // nop, halt, ld and unknown codes
      endcase
    end
  end

  // sequencer and pc
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_fetch;
      pc    <= '0;
    end else if (!run) begin
      state <= st_fetch;
      pc    <= '0;
    end else begin
      case (state)
        st_fetch: state <= st_exec;  // program RAM reads pc this cycle
        st_exec: begin
          if (op == op_halt) begin
            state <= st_halted;
          end else begin
            state <= (op == op_ld) ? st_mem_wait : st_fetch;
            pc    <= take_jump ? pc_w'(operand) : pc + 1'b1;
          end
        end
        st_mem_wait: state <= st_fetch;
        st_halted:   state <= st_halted;
        default:     state <= st_fetch;
      endcase
    end
  end

  // shift-register stack, zero fill from the bottom
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < stack_depth; i++) begin
        stack[i] <= '0;
      end
    end else if (!run) begin
      for (int i = 0; i < stack_depth; i++) begin
        stack[i] <= '0;
      end
    end else if (push_en) begin
      stack[0] <= push_val;
      for (int i = 1; i < stack_depth; i++) begin
        stack[i] <= stack[i-1];  // bottom entry falls off
      end
    end else if (pop_en || alu_en) begin
      stack[0] <= alu_en ? alu_res : stack[1];
      for (int i = 1; i < stack_depth - 1; i++) begin
        stack[i] <= stack[i+1];
      end
      stack[stack_depth-1] <= '0;
    end
  end

  always_comb begin
    for (int i = 0; i < led_stack_rows; i++) begin
      stack_view[i] = stack[i];
    end
  end

endmodule

//--- design/led_matrix_scan.sv
module led_matrix_scan #(
  parameter int scan_period = 27000,
  parameter int scan_gap    = 500
) (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic [stack_cpu_pkg::insn_w-1:0] insn,
  input  logic [stack_cpu_pkg::led_stack_rows-1:0][stack_cpu_pkg::data_w-1:0] stack_view,
  input  logic [stack_cpu_pkg::pc_w-1:0]   pc,
  output logic [8:0]                       led_row,
  output logic [7:0]                       led_col
);
  import stack_cpu_pkg::*;

  localparam int cnt_w = $clog2(scan_period);

  logic [cnt_w-1:0] scan_cnt;
  logic [3:0]       row_index;
  logic             row_on;

  // seven segments, a in bit 7 down to g in bit 1, dp in bit 0
  function automatic logic [7:0] encode_7seg(input logic [4:0] n);
    logic [6:0] seg;
    case (n[3:0])
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110010;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;  // f
    endcase
    return {seg, n[4]};
  endfunction

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_cnt  <= '0;
      row_index <= '0;
    end else if (scan_cnt == cnt_w'(scan_period - 1)) begin
      scan_cnt  <= '0;
      row_index <= (row_index == 4'd8) ? 4'd0 : row_index + 1'b1;
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // blank near row changes to avoid ghosting
  assign row_on  = (scan_cnt >= cnt_w'(scan_gap)) &&
                   (scan_cnt < cnt_w'(scan_period - scan_gap));
  assign led_row = row_on ? (9'b1 << row_index) : 9'b0;

  always_comb begin
    case (row_index)
      4'd0: led_col = insn[insn_w-1:data_w];
      4'd1: led_col = insn[data_w-1:0];
      4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: led_col = stack_view[row_index - 4'd2];
      4'd8: led_col = encode_7seg(pc[4:0]);
      default: led_col = 8'b0;
    endcase
  end

endmodule

//--- design/board_top.sv
module board_top #(
  parameter int clks_per_bit = 234,
  parameter int scan_period  = 27000,
  parameter int scan_gap     = 500,
  parameter int stack_depth  = 16
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  output logic       uart_tx,
  output logic [7:0] led_col,
  output logic [8:0] led_row
);
  import stack_cpu_pkg::*;

  logic [7:0]        rx_data;
  logic              rx_data_wr;
  logic [data_w-1:0] tx_data;
  logic              tx_en;

  logic              prog_we;
  logic [pc_w-1:0]   prog_addr;
  logic [insn_w-1:0] prog_wdata;
  logic              prog_done;

  logic [insn_w-1:0] insn;
  logic [pc_w-1:0]   pc;
  logic [addr_w-1:0] mem_addr;
  logic              mem_wr;
  logic [data_w-1:0] wr_data;
  logic [data_w-1:0] rd_data;
  logic [led_stack_rows-1:0][data_w-1:0] stack_view;

  logic              port_wr;

  // store to the tx port, RAM still takes the write
  assign port_wr = mem_wr && (mem_addr == tx_port_addr);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_en <= 1'b0;
    end else begin
      tx_en <= port_wr;  // one-cycle strobe
    end
  end

  always_ff @(posedge sys_clk) begin
    if (port_wr) begin
      tx_data <= wr_data;
    end
  end

  uart #(.clks_per_bit(clks_per_bit)) i_uart (
    .sys_clk, .rst_n, .uart_rx, .uart_tx,
    .rx_data, .rx_data_wr, .tx_data, .tx_en
  );

  program_loader i_loader (
    .sys_clk, .rst_n, .rx_data, .rx_data_wr,
    .prog_we, .prog_addr, .prog_wdata, .prog_done
  );

  sdp_ram #(.addr_bits(pc_w), .data_bits(insn_w)) prog_mem (
    .sys_clk, .we(prog_we), .waddr(prog_addr), .wdata(prog_wdata),
    .raddr(pc), .rdata(insn)
  );

  // one address for both ports
  sdp_ram #(.addr_bits(addr_w), .data_bits(data_w)) data_mem (
    .sys_clk, .we(mem_wr), .waddr(mem_addr), .wdata(wr_data),
    .raddr(mem_addr), .rdata(rd_data)
  );

  stack_cpu #(.stack_depth(stack_depth)) i_cpu (
    .sys_clk, .rst_n, .run(prog_done), .insn, .pc,
    .mem_addr, .mem_wr, .wr_data, .rd_data, .stack_view
  );

  led_matrix_scan #(.scan_period(scan_period), .scan_gap(scan_gap)) i_scan (
    .sys_clk, .rst_n, .insn, .stack_view, .pc, .led_row, .led_col
  );

endmodule

//--- testbench/board_top_chk.sv
module board_top_chk #(
  parameter int scan_period = 27000,
  parameter int scan_gap    = 500
) (
  input logic       sys_clk,
  input logic       rst_n,
  input logic       uart_tx,
  input logic       tx_en,
  input logic       rx_data_wr,
  input logic       prog_we,
  input logic [8:0] led_row
);

  int unsigned scan_pos;  // own model of the row timer
  int unsigned scan_row;
  logic        in_gap;
  int unsigned fail_count = 0;  // assertion failures so far

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_pos <= 0;
      scan_row <= 0;
    end else if (scan_pos == scan_period - 1) begin
      scan_pos <= 0;
      scan_row <= (scan_row == 8) ? 0 : scan_row + 1;  // rows 0 to 8
    end else begin
      scan_pos <= scan_pos + 1;
    end
  end

  assign in_gap = (scan_pos < scan_gap) || (scan_pos >= scan_period - scan_gap);

  a_row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !in_gap |-> led_row == 9'(1 << scan_row))
    else begin
      $error("led row is not the one-hot row of the scan position");
      fail_count++;
    end
  a_row_gap: assert property (@(posedge sys_clk) disable iff (!rst_n) in_gap |-> led_row == '0)
    else begin
      $error("led row lit inside the blanking gap");
      fail_count++;
    end
  // first edge has no history yet
  a_tx_reset: assert property (@(posedge sys_clk) !rst_n && $past(!rst_n) |-> uart_tx)
    else begin
      $error("uart_tx not idle during reset");
      fail_count++;
    end
  a_tx_en_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n) tx_en |=> !tx_en)
    else begin
      $error("tx_en held for two cycles");
      fail_count++;
    end
  a_prog_we: assert property (@(posedge sys_clk) disable iff (!rst_n) prog_we |-> $past(rx_data_wr))
    else begin
      $error("prog_we without a byte strobe one cycle before");
      fail_count++;
    end

endmodule

bind board_top board_top_chk #(.scan_period(scan_period), .scan_gap(scan_gap)) i_chk (
  .sys_clk, .rst_n, .uart_tx, .tx_en, .rx_data_wr, .prog_we, .led_row
);

//--- testbench/board_top_tb.sv
module board_top_tb;
  import stack_cpu_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int scan_period  = 40;
  localparam int scan_gap     = 5;
  localparam int stack_depth  = 8;
  localparam int bit_time     = clks_per_bit * 20;
  localparam int pad_nops     = clks_per_bit * 10 / 2 + 8;  // more than one byte time
  localparam int budget_bytes = 4 * pad_nops + 142;         // sent plus received, all tests
  localparam logic [7:0] halt_pc_code = 8'b1111_0011;       // digit 3 with dp, pc 19

  logic        sys_clk;
  logic        rst_n;
  logic        uart_rx;
  logic        uart_tx;
  logic [7:0]  led_col;
  logic [8:0]  led_row;
  logic [7:0]  rx_q[$];   // bytes decoded from uart_tx
  logic [7:0]  exp_q[$];
  logic [15:0] prog[$];
  logic [7:0]  a;
  logic [7:0]  b;
  int          seed = 65243;
  int          checks;
  int          errors;
  int          test_errors;
  int          tests_run;

  board_top #(
    .clks_per_bit(clks_per_bit), .scan_period(scan_period),
    .scan_gap(scan_gap), .stack_depth(stack_depth)
  ) i_dut (
    .sys_clk, .rst_n, .uart_rx, .uart_tx, .led_col, .led_row
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  function automatic logic [15:0] encode(input op_e op, input logic [7:0] arg = 8'h00);
    return {op, arg};
  endfunction

  // 8N1, lsb first
  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge sys_clk);
      uart_rx = frame[i];
      repeat (clks_per_bit - 1) @(negedge sys_clk);
    end
  endtask

  task automatic load_program();
    rx_q.delete();
    prog.push_back(prog_end_word);
    foreach (prog[i]) begin
      send_byte(prog[i][15:8]);  // high byte first
      send_byte(prog[i][7:0]);
    end
    prog.delete();
  endtask

  task automatic check_bytes();
    int waited;
    waited = 0;
    while (rx_q.size() < exp_q.size() && waited < (exp_q.size() + 2) * 40 * clks_per_bit) begin
      @(negedge sys_clk);
      waited++;
    end
    foreach (exp_q[i]) begin
      checks++;
      assert (i < rx_q.size()) else begin
        $display("%0t: byte %0d was never sent on uart_tx", $time, i);
        test_errors++;
      end
      if (i < rx_q.size()) begin
        assert (rx_q[i] == exp_q[i]) else begin
          $display("MISMATCH %0t: uart byte %0d is %h, expected %h", $time, i, rx_q[i], exp_q[i]);
          test_errors++;
        end
      end
    end
    exp_q.delete();
  endtask

  task automatic check_row(input int row, input logic [7:0] expected);
    int waited;
    waited = 0;
    while (led_row != (9'b1 << row) && waited < 2 * 9 * scan_period) begin
      @(negedge sys_clk);
      waited++;
    end
    checks++;
    assert (led_row == (9'b1 << row)) else begin
      $display("%0t: led row %0d never came on", $time, row);
      test_errors++;
    end
    if (led_row == (9'b1 << row)) begin
      assert (led_col == expected) else begin
        $display("MISMATCH %0t: row %0d shows %h, expected %h", $time, row, led_col, expected);
        test_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    errors += test_errors;
    test_errors = 0;
  endtask

  initial begin : uart_monitor
    logic [7:0] value;
    @(posedge rst_n);
    forever begin
      @(negedge uart_tx);
      #(bit_time / 2 + 10);  // mid start bit, away from clock edges
      for (int i = 0; i < 8; i++) begin
        #(bit_time);
        value[i] = uart_tx;
      end
      #(bit_time);
      assert (uart_tx === 1'b1) else begin
        $display("%0t: uart_tx byte %h has no stop bit", $time, value);
        errors++;
      end
      rx_q.push_back(value);
    end
  end

  initial begin : watchdog
    #(budget_bytes * 10 * bit_time + 200_000);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    uart_rx     = 1'b1;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    repeat (5) @(negedge sys_clk);
    rst_n = 1'b1;
    repeat (2) @(negedge sys_clk);

    a = 8'h3c;
    b = 8'hd7;
    prog = {encode(op_push, a), encode(op_push, b), encode(op_add),
            encode(op_st, tx_port_addr), encode(op_halt)};
    load_program();
    exp_q.push_back(8'(a + b));  // wraps
    check_bytes();
    prog = {encode(op_push, a), encode(op_push, b), encode(op_sub),
            encode(op_st, tx_port_addr), encode(op_halt)};
    load_program();
    exp_q.push_back(8'(a - b));
    check_bytes();
    finish_test("add and sub to port");

    a = 8'($random(seed));
    b = 8'($random(seed));
    prog = {encode(op_push, a), encode(op_push, b), encode(op_and), encode(op_st, 8'd20),
            encode(op_ld, 8'd20), encode(op_st, tx_port_addr)};
    repeat (pad_nops) prog.push_back(encode(op_nop));
    prog = {prog, encode(op_push, a), encode(op_push, b), encode(op_or), encode(op_st, 8'd20),
            encode(op_ld, 8'd20), encode(op_st, tx_port_addr), encode(op_halt)};
    load_program();
    exp_q = {a & b, a | b};
    check_bytes();
    finish_test("logic and memory");

    // countdown, halt sits right after the loop
    prog = {encode(op_push, 8'd3), encode(op_dup), encode(op_jz, 8'(pad_nops + 8)),
            encode(op_dup), encode(op_st, tx_port_addr)};
    repeat (pad_nops) prog.push_back(encode(op_nop));
    prog = {prog, encode(op_push, 8'd1), encode(op_sub), encode(op_jmp, 8'd1), encode(op_halt)};
    load_program();
    exp_q = {8'd3, 8'd2, 8'd1};
    check_bytes();
    finish_test("countdown loop");

    prog = {encode(op_push, 8'ha5), encode(op_st, tx_port_addr), encode(op_nop),
            encode(op_jmp, 8'd2)};
    load_program();
    exp_q.push_back(8'ha5);
    check_bytes();
    prog = {encode(op_push, 8'h4e), encode(op_st, tx_port_addr), encode(op_halt)};
    load_program();
    exp_q.push_back(8'h4e);
    check_bytes();
    finish_test("program reload");

    prog = {encode(op_push, 8'h21), encode(op_push, 8'h5a), encode(op_or), encode(op_dup),
            encode(op_st, tx_port_addr)};
    repeat (14) prog.push_back(encode(op_nop));
    prog.push_back(encode(op_halt));  // pc 19
    load_program();
    exp_q.push_back(8'h21 | 8'h5a);
    check_bytes();
    check_row(0, 8'(op_halt));
    check_row(1, 8'h00);
    check_row(2, 8'h21 | 8'h5a);
    check_row(3, 8'h00);
    check_row(8, halt_pc_code);
    finish_test("led display");

    errors += i_dut.i_chk.fail_count;  // bound assertion failures
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/stack_cpu_pkg.sv
design/uart.sv
design/program_loader.sv
design/sdp_ram.sv
design/stack_cpu.sv
design/led_matrix_scan.sv
design/board_top.sv
testbench/board_top_chk.sv
testbench/board_top_tb.sv
